// ==== files.f ====
+incdir+include
hw/vunit_pkg.sv
hw/vunit_fifo.sv
hw/vunit_dispatch.sv
hw/vunit_alu.sv
hw/vunit_mul.sv
hw/vunit_retire.sv
hw/vunit_top.sv
verification/vunit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vunit_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= test passed
FAIL_MSG  ?= test failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	if echo "$$out" | grep -q "$(PASS_MSG)" && ! echo "$$out" | grep -q "$(FAIL_MSG)"; then \
	    echo "RESULT: PASS"; \
	else \
	    echo "RESULT: FAIL"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/vunit_tb.sv ====
/* Self-checking testbench for vunit_top. Inputs change on the falling edge,
   handshakes and results are sampled on the rising edge */
`timescale 1ns/10ps
`default_nettype none

`include "vunit_settings.svh"

module vunit_tb;

    localparam int WAIT_LIMIT   = 200;
    localparam int READY_LOW    = 0;
    localparam int READY_HIGH   = 1;
    localparam int READY_RANDOM = 2;
    localparam int MIX_ALU      = 0;
    localparam int MIX_MUL      = 1;
    localparam int MIX_BOTH     = 2;

    logic                     clk = 1'b0;
    logic                     arst_n;
    logic                     in_valid;
    logic                     in_ready;
    vunit_pkg::op_unit_e      in_unit;
    vunit_pkg::alu_op_e       in_op;
    logic [`VUNIT_ID_W-1:0]   in_id;
    logic [`VUNIT_VD_W-1:0]   in_vd;
    logic [`VUNIT_DATA_W-1:0] in_a;
    logic [`VUNIT_DATA_W-1:0] in_b;
    logic                     out_valid;
    logic                     out_ready = 1'b0;
    logic [`VUNIT_ID_W-1:0]   out_id;
    logic [`VUNIT_VD_W-1:0]   out_vd;
    logic [`VUNIT_DATA_W-1:0] out_data;

    vunit_pkg::result_t       exp_q[$];
    logic [`VUNIT_ID_W-1:0]   next_id;
    logic [`VUNIT_VD_W-1:0]   next_vd;
    int                       ready_mode = READY_LOW;
    int                       err_cnt;
    int                       test_errs;
    int                       test_cnt;
    int                       fail_cnt;
    int                       checked;
    bit                       hung;
    string                    test_name;

    vunit_top u_vunit_top (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .in_unit_i   (in_unit),
        .in_op_i     (in_op),
        .in_id_i     (in_id),
        .in_vd_i     (in_vd),
        .in_a_i      (in_a),
        .in_b_i      (in_b),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready),
        .out_id_o    (out_id),
        .out_vd_o    (out_vd),
        .out_data_o  (out_data)
    );

    always #20 clk = ~clk;

    // Expected data, multiply keeps the low word of the full product
    function automatic logic [`VUNIT_DATA_W-1:0] expected_data(vunit_pkg::op_unit_e unit,
            vunit_pkg::alu_op_e op, logic [`VUNIT_DATA_W-1:0] a, logic [`VUNIT_DATA_W-1:0] b);
        logic [2*`VUNIT_DATA_W-1:0] wide;
        wide = {{`VUNIT_DATA_W{1'b0}}, a} * {{`VUNIT_DATA_W{1'b0}}, b};
        if (unit == vunit_pkg::UNIT_MUL) begin
            return wide[`VUNIT_DATA_W-1:0];
        end
        case (op)
            vunit_pkg::OP_SUB: return a - b;
            vunit_pkg::OP_AND: return a & b;
            vunit_pkg::OP_XOR: return a ^ b;
            default:           return a + b;
        endcase
    endfunction

    always @(negedge clk) begin
        logic [31:0] r;
        r = $urandom;
        out_ready = (ready_mode == READY_HIGH) || (ready_mode == READY_RANDOM && r[0]);
    end

    // Every output handshake must match the oldest accepted operation
    always @(posedge clk) begin
        vunit_pkg::result_t head;
        if (arst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("%s: result id %0d came out with nothing outstanding", test_name, out_id);
                err_cnt++;
            end else begin
                head = exp_q.pop_front();
                checked++;
                if (out_id !== head.id) begin
                    $display("[ERROR] %s: id expected %0d actual %0d", test_name, head.id, out_id);
                    err_cnt++;
                end
                if (out_vd !== head.vd) begin
                    $display("[ERROR] %s: vd expected %0d actual %0d", test_name, head.vd, out_vd);
                    err_cnt++;
                end
                if (out_data !== head.data) begin
                    $display("[ERROR] %s: data expected %h actual %h", test_name, head.data,
                             out_data);
                    err_cnt++;
                end
            end
        end
    end

    task automatic start_test(input string name);
        test_name = name;
        test_errs = err_cnt;
    endtask

    task automatic finish_test();
        test_cnt++;
        if (err_cnt == test_errs) begin
            $display("%s: ok", test_name);
        end else begin
            fail_cnt++;
            $display("%s: FAILED with %0d errors", test_name, err_cnt - test_errs);
        end
    endtask

    task automatic set_ready_mode(input int mode);
        @(posedge clk);
        ready_mode = mode;
        @(negedge clk);
    endtask

    // Drives one operation and reports whether the next rising edge took it
    task automatic offer_op(input vunit_pkg::op_unit_e unit, input vunit_pkg::alu_op_e op,
            input logic [`VUNIT_DATA_W-1:0] a, input logic [`VUNIT_DATA_W-1:0] b,
            output bit taken);
        vunit_pkg::result_t exp;
        logic [31:0]        r;
        @(negedge clk);
        in_valid = 1'b1;
        in_unit  = unit;
        in_op    = op;
        in_id    = next_id;
        in_vd    = next_vd;
        in_a     = a;
        in_b     = b;
        @(posedge clk);
        taken = in_ready;
        if (taken) begin
            exp.id   = next_id;
            exp.vd   = next_vd;
            exp.data = expected_data(unit, op, a, b);
            exp_q.push_back(exp);
            next_id = next_id + 1'b1;
            r = $urandom;
            next_vd = r[`VUNIT_VD_W-1:0];
        end
    endtask

    task automatic send_op(input vunit_pkg::op_unit_e unit, input vunit_pkg::alu_op_e op,
            input logic [`VUNIT_DATA_W-1:0] a, input logic [`VUNIT_DATA_W-1:0] b);
        bit taken;
        int waited;
        taken  = 1'b0;
        waited = 0;
        while (!taken && !hung && waited < WAIT_LIMIT) begin
            offer_op(unit, op, a, b, taken);
            waited++;
        end
        if (!taken && !hung) begin
            $display("%s: operation id %0d was never accepted", test_name, next_id);
            err_cnt++;
            hung = 1'b1;
        end
    endtask

    task automatic send_random(input int mix);
        logic [31:0]         r;
        vunit_pkg::op_unit_e unit;
        r = $urandom;
        if (mix == MIX_ALU) begin
            unit = vunit_pkg::UNIT_ALU;
        end else if (mix == MIX_MUL) begin
            unit = vunit_pkg::UNIT_MUL;
        end else begin
            unit = vunit_pkg::op_unit_e'(r[2]);
        end
        send_op(unit, vunit_pkg::alu_op_e'(r[1:0]), $urandom, $urandom);
    endtask

    task automatic idle_input();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        idle_input();
        while (exp_q.size() != 0 && !hung && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0 && !hung) begin
            $display("%s: %0d results never came out", test_name, exp_q.size());
            err_cnt++;
            hung = 1'b1;
        end
        // A few quiet cycles catch any result that was never sent
        repeat (4) begin
            @(posedge clk);
            if (exp_q.size() == 0 && out_valid) begin
                $display("%s: result id %0d is valid with nothing outstanding", test_name,
                         out_id);
                err_cnt++;
            end
        end
    endtask

    task automatic run_backpressure();
        vunit_pkg::op_unit_e unit;
        vunit_pkg::alu_op_e  op;
        logic [31:0]         r;
        logic [31:0]         a;
        logic [31:0]         b;
        bit                  taken;
        int                  accepted;
        start_test("backpressure");
        set_ready_mode(READY_LOW);
        accepted = 0;
        taken    = 1'b1;
        unit     = vunit_pkg::UNIT_MUL;
        for (int c = 0; c < 12; c++) begin
            if (taken) begin
                r    = $urandom;
                unit = (unit == vunit_pkg::UNIT_ALU) ? vunit_pkg::UNIT_MUL : vunit_pkg::UNIT_ALU;
                op   = vunit_pkg::alu_op_e'(r[1:0]);
                a    = $urandom;
                b    = $urandom;
            end
            offer_op(unit, op, a, b, taken);
            if (taken) begin
                accepted++;
            end
        end
        idle_input();
        if (accepted != `VUNIT_ORDER_DEPTH) begin
            $display("[ERROR] %s: accepted expected %0d actual %0d", test_name,
                     `VUNIT_ORDER_DEPTH, accepted);
            err_cnt++;
        end
        set_ready_mode(READY_RANDOM);
        repeat (40) send_random(MIX_BOTH);
        wait_drain();
        set_ready_mode(READY_HIGH);
        finish_test();
    endtask

    initial begin
        void'($urandom(32'hed3b_5b26));
        arst_n   = 1'b0;
        in_valid = 1'b0;
        in_unit  = vunit_pkg::UNIT_ALU;
        in_op    = vunit_pkg::OP_ADD;
        in_id    = '0;
        in_vd    = '0;
        in_a     = '0;
        in_b     = '0;
        next_id  = '0;
        next_vd  = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        start_test("reset");
        @(posedge clk);
        if (out_valid !== 1'b0) begin
            $display("[ERROR] %s: out_valid expected 0 actual %b", test_name, out_valid);
            err_cnt++;
        end
        if (in_ready !== 1'b1) begin
            $display("[ERROR] %s: in_ready expected 1 actual %b", test_name, in_ready);
            err_cnt++;
        end
        finish_test();

        set_ready_mode(READY_HIGH);
        start_test("alu");
        repeat (32) send_random(MIX_ALU);
        wait_drain();
        finish_test();

        start_test("mul");
        repeat (32) send_random(MIX_MUL);
        wait_drain();
        finish_test();

        // Multiply first, then ALU ops that finish earlier and must wait
        start_test("order");
        repeat (8) begin
            send_random(MIX_MUL);
            send_random(MIX_ALU);
            send_random(MIX_ALU);
        end
        repeat (24) send_random(MIX_BOTH);
        wait_drain();
        finish_test();

        run_backpressure();

        $display("%0d tests, %0d failing, %0d results checked, %0d errors",
                 test_cnt, fail_cnt, checked, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/vunit_top.sv ====
/* Unit multiplexer top with ALU and multiply units. At most VUNIT_ORDER_DEPTH
   operations in flight; minimum latency one cycle for an ALU operation */
`timescale 1ns/10ps
`default_nettype none

`include "vunit_settings.svh"

module vunit_top (
    input  wire logic                     clk_i,
    input  wire logic                     arst_n_i,
    input  wire logic                     in_valid_i,
    output logic                          in_ready_o,
    input  vunit_pkg::op_unit_e           in_unit_i,
    input  vunit_pkg::alu_op_e            in_op_i,
    input  wire logic [`VUNIT_ID_W-1:0]   in_id_i,
    input  wire logic [`VUNIT_VD_W-1:0]   in_vd_i,
    input  wire logic [`VUNIT_DATA_W-1:0] in_a_i,
    input  wire logic [`VUNIT_DATA_W-1:0] in_b_i,
    output logic                          out_valid_o,
    input  wire logic                     out_ready_i,
    output logic [`VUNIT_ID_W-1:0]        out_id_o,
    output logic [`VUNIT_VD_W-1:0]        out_vd_o,
    output logic [`VUNIT_DATA_W-1:0]      out_data_o
);

    logic                     alu_valid;
    logic                     alu_ready;
    logic                     mul_valid;
    logic                     mul_ready;
    logic                     order_valid;
    logic                     order_ready;
    vunit_pkg::op_unit_e      order_unit;

    // Unit result side
    logic                     alu_res_valid;
    logic                     alu_res_ready;
    logic [`VUNIT_ID_W-1:0]   alu_res_id;
    logic [`VUNIT_VD_W-1:0]   alu_res_vd;
    logic [`VUNIT_DATA_W-1:0] alu_res_data;
    logic                     mul_res_valid;
    logic                     mul_res_ready;
    logic [`VUNIT_ID_W-1:0]   mul_res_id;
    logic [`VUNIT_VD_W-1:0]   mul_res_vd;
    logic [`VUNIT_DATA_W-1:0] mul_res_data;

    vunit_dispatch u_dispatch (
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .in_unit_i     (in_unit_i),
        .alu_valid_o   (alu_valid),
        .alu_ready_i   (alu_ready),
        .mul_valid_o   (mul_valid),
        .mul_ready_i   (mul_ready),
        .order_valid_o (order_valid),
        .order_ready_i (order_ready),
        .order_unit_o  (order_unit)
    );

    vunit_alu u_alu (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (alu_valid),
        .ready_o  (alu_ready),
        .op_i     (in_op_i),
        .id_i     (in_id_i),
        .vd_i     (in_vd_i),
        .a_i      (in_a_i),
        .b_i      (in_b_i),
        .valid_o  (alu_res_valid),
        .ready_i  (alu_res_ready),
        .id_o     (alu_res_id),
        .vd_o     (alu_res_vd),
        .data_o   (alu_res_data)
    );

    vunit_mul u_mul (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (mul_valid),
        .ready_o  (mul_ready),
        .id_i     (in_id_i),
        .vd_i     (in_vd_i),
        .a_i      (in_a_i),
        .b_i      (in_b_i),
        .valid_o  (mul_res_valid),
        .ready_i  (mul_res_ready),
        .id_o     (mul_res_id),
        .vd_o     (mul_res_vd),
        .data_o   (mul_res_data)
    );

    vunit_retire u_retire (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .order_valid_i (order_valid),
        .order_ready_o (order_ready),
        .order_unit_i  (order_unit),
        .alu_valid_i   (alu_res_valid),
        .alu_id_i      (alu_res_id),
        .alu_vd_i      (alu_res_vd),
        .alu_data_i    (alu_res_data),
        .mul_valid_i   (mul_res_valid),
        .mul_id_i      (mul_res_id),
        .mul_vd_i      (mul_res_vd),
        .mul_data_i    (mul_res_data),
        .alu_ready_o   (alu_res_ready),
        .mul_ready_o   (mul_res_ready),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .out_id_o      (out_id_o),
        .out_vd_o      (out_vd_o),
        .out_data_o    (out_data_o)
    );

endmodule

`default_nettype wire

// ==== hw/vunit_retire.sv ====
/* Output side. Results leave in acceptance order; only the unit at the head of
   the order queue is allowed to hand over its result */
`timescale 1ns/10ps
`default_nettype none

`include "vunit_settings.svh"

module vunit_retire (
    input  wire logic                     clk_i,
    input  wire logic                     arst_n_i,
    input  wire logic                     order_valid_i,
    output logic                          order_ready_o,
    input  vunit_pkg::op_unit_e           order_unit_i,
    input  wire logic                     alu_valid_i,
    input  wire logic [`VUNIT_ID_W-1:0]   alu_id_i,
    input  wire logic [`VUNIT_VD_W-1:0]   alu_vd_i,
    input  wire logic [`VUNIT_DATA_W-1:0] alu_data_i,
    input  wire logic                     mul_valid_i,
    input  wire logic [`VUNIT_ID_W-1:0]   mul_id_i,
    input  wire logic [`VUNIT_VD_W-1:0]   mul_vd_i,
    input  wire logic [`VUNIT_DATA_W-1:0] mul_data_i,
    output logic                          alu_ready_o,
    output logic                          mul_ready_o,
    output logic                          out_valid_o,
    input  wire logic                     out_ready_i,
    output logic [`VUNIT_ID_W-1:0]        out_id_o,
    output logic [`VUNIT_VD_W-1:0]        out_vd_o,
    output logic [`VUNIT_DATA_W-1:0]      out_data_o
);

    logic                head_valid;
    vunit_pkg::op_unit_e head_unit;
    logic                head_mul;

    vunit_fifo #(
        .payload_t   (vunit_pkg::op_unit_e),
        .depth       (`VUNIT_ORDER_DEPTH)
    ) u_order_q (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .enq_valid_i (order_valid_i),
        .enq_ready_o (order_ready_o),
        .enq_data_i  (order_unit_i),
        .deq_valid_o (head_valid),
        .deq_ready_i (out_valid_o & out_ready_i),
        .deq_data_o  (head_unit)
    );

    assign head_mul    = (head_unit == vunit_pkg::UNIT_MUL);
    assign alu_ready_o = head_valid & ~head_mul & out_ready_i;
    assign mul_ready_o = head_valid & head_mul & out_ready_i;

    always_comb begin
        out_valid_o = head_valid & (head_mul ? mul_valid_i : alu_valid_i);
        out_id_o    = head_mul ? mul_id_i   : alu_id_i;
        out_vd_o    = head_mul ? mul_vd_i   : alu_vd_i;
        out_data_o  = head_mul ? mul_data_i : alu_data_i;
    end

    // Every buffered unit result has its order entry, so nothing is valid on an empty queue
    a_no_orphan: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !head_valid |-> !(out_valid_o || alu_valid_i || mul_valid_i));

endmodule

`default_nettype wire

// ==== hw/vunit_mul.sv ====
/* Pipelined 32-bit multiply returning the low word. The whole pipeline holds
   when its last stage is occupied and the result buffer is full */
`timescale 1ns/10ps
`default_nettype none

`include "vunit_settings.svh"

module vunit_mul (
    input  wire logic                     clk_i,
    input  wire logic                     arst_n_i,
    input  wire logic                     valid_i,
    output logic                          ready_o,
    input  wire logic [`VUNIT_ID_W-1:0]   id_i,
    input  wire logic [`VUNIT_VD_W-1:0]   vd_i,
    input  wire logic [`VUNIT_DATA_W-1:0] a_i,
    input  wire logic [`VUNIT_DATA_W-1:0] b_i,
    output logic                          valid_o,
    input  wire logic                     ready_i,
    output logic [`VUNIT_ID_W-1:0]        id_o,
    output logic [`VUNIT_VD_W-1:0]        vd_o,
    output logic [`VUNIT_DATA_W-1:0]      data_o
);

    localparam int STAGES = `VUNIT_MUL_STAGES;

    logic [STAGES-1:0]                    stage_valid;
    vunit_pkg::result_t [STAGES-1:0]      stage_res;
    vunit_pkg::result_t                   deq_res;
    logic [`VUNIT_DATA_W-1:0]             product;
    logic                                 buf_ready;
    logic                                 stall;

    // Low word only, upper half of the product is dropped
    assign product = a_i * b_i;
    assign stall   = stage_valid[STAGES-1] & ~buf_ready;
    assign ready_o = ~stall;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stage_valid <= '0;
        end else if (!stall) begin
            stage_valid[0] <= valid_i;
            for (int i = 1; i < STAGES; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall) begin
            stage_res[0].id   <= id_i;
            stage_res[0].vd   <= vd_i;
            stage_res[0].data <= product;
            for (int i = 1; i < STAGES; i++) begin
                stage_res[i] <= stage_res[i-1];
            end
        end
    end

    vunit_fifo #(
        .payload_t   (vunit_pkg::result_t),
        .depth       (`VUNIT_RES_DEPTH)
    ) u_res_buf (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .enq_valid_i (stage_valid[STAGES-1]),
        .enq_ready_o (buf_ready),
        .enq_data_i  (stage_res[STAGES-1]),
        .deq_valid_o (valid_o),
        .deq_ready_i (ready_i),
        .deq_data_o  (deq_res)
    );

    assign id_o   = deq_res.id;
    assign vd_o   = deq_res.vd;
    assign data_o = deq_res.data;

    a_stall_holds: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        stall |=> $stable(stage_valid) && $stable(stage_res));

endmodule

`default_nettype wire

// ==== hw/vunit_alu.sv ====
/* One-cycle ALU for add, sub, and, xor. Results wait in a small buffer until
   this unit reaches the head of the order queue */
`timescale 1ns/10ps
`default_nettype none

`include "vunit_settings.svh"

module vunit_alu (
    input  wire logic                     clk_i,
    input  wire logic                     arst_n_i,
    input  wire logic                     valid_i,
    output logic                          ready_o,
    input  vunit_pkg::alu_op_e            op_i,
    input  wire logic [`VUNIT_ID_W-1:0]   id_i,
    input  wire logic [`VUNIT_VD_W-1:0]   vd_i,
    input  wire logic [`VUNIT_DATA_W-1:0] a_i,
    input  wire logic [`VUNIT_DATA_W-1:0] b_i,
    output logic                          valid_o,
    input  wire logic                     ready_i,
    output logic [`VUNIT_ID_W-1:0]        id_o,
    output logic [`VUNIT_VD_W-1:0]        vd_o,
    output logic [`VUNIT_DATA_W-1:0]      data_o
);

    vunit_pkg::result_t enq_res;
    vunit_pkg::result_t deq_res;

    always_comb begin
        enq_res.id = id_i;
        enq_res.vd = vd_i;
        case (op_i)
            vunit_pkg::OP_SUB: enq_res.data = a_i - b_i;
            vunit_pkg::OP_AND: enq_res.data = a_i & b_i;
            vunit_pkg::OP_XOR: enq_res.data = a_i ^ b_i;
            default:           enq_res.data = a_i + b_i;
        endcase
    end

    vunit_fifo #(
        .payload_t   (vunit_pkg::result_t),
        .depth       (`VUNIT_RES_DEPTH)
    ) u_res_buf (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .enq_valid_i (valid_i),
        .enq_ready_o (ready_o),
        .enq_data_i  (enq_res),
        .deq_valid_o (valid_o),
        .deq_ready_i (ready_i),
        .deq_data_o  (deq_res)
    );

    assign id_o   = deq_res.id;
    assign vd_o   = deq_res.vd;
    assign data_o = deq_res.data;

endmodule

`default_nettype wire

// ==== hw/vunit_dispatch.sv ====
/* Input side of the multiplexer. An operation is taken only when its unit and the
   order queue can both accept it in the same cycle */
`timescale 1ns/10ps
`default_nettype none

module vunit_dispatch (
    input  wire logic                 in_valid_i,
    output logic                      in_ready_o,
    input  vunit_pkg::op_unit_e       in_unit_i,
    output logic                      alu_valid_o,
    input  wire logic                 alu_ready_i,
    output logic                      mul_valid_o,
    input  wire logic                 mul_ready_i,
    output logic                      order_valid_o,
    input  wire logic                 order_ready_i,
    output vunit_pkg::op_unit_e       order_unit_o
);

    logic sel_ready;
    logic in_fire;

    assign sel_ready  = (in_unit_i == vunit_pkg::UNIT_MUL) ? mul_ready_i : alu_ready_i;
    assign in_ready_o = sel_ready & order_ready_i;
    assign in_fire    = in_valid_i & in_ready_o;

    // Unit and order queue see the same handshake
    assign alu_valid_o   = in_fire & (in_unit_i == vunit_pkg::UNIT_ALU);
    assign mul_valid_o   = in_fire & (in_unit_i == vunit_pkg::UNIT_MUL);
    assign order_valid_o = in_fire;
    assign order_unit_o  = in_unit_i;

    always_comb begin
        if (in_valid_i) begin
            assert (!$isunknown(in_unit_i))
                else $error("unit code unknown while in_valid_i is high");
        end
    end

endmodule

`default_nettype wire

// ==== hw/vunit_fifo.sv ====
/* Registered FIFO, no fall-through: an entry is visible one cycle after enqueue.
   Enqueue ready drops when full. Storage has no reset */
`timescale 1ns/10ps
`default_nettype none

module vunit_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 2
) (
    input  wire logic clk_i,
    input  wire logic arst_n_i,
    input  wire logic enq_valid_i,
    output logic      enq_ready_o,
    input  payload_t  enq_data_i,
    output logic      deq_valid_o,
    input  wire logic deq_ready_i,
    output payload_t  deq_data_o
);

    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int CNT_W = $clog2(depth + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(depth - 1);

    payload_t         mem [depth];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             enq_fire;
    logic             deq_fire;

    assign enq_ready_o = (count != CNT_W'(depth));
    assign deq_valid_o = (count != '0);
    assign enq_fire    = enq_valid_i & enq_ready_o;
    assign deq_fire    = deq_valid_o & deq_ready_i;
    assign deq_data_o  = mem[rd_ptr];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (deq_fire) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(enq_fire) - CNT_W'(deq_fire);
        end
    end

    always_ff @(posedge clk_i) begin
        if (enq_fire) begin
            mem[wr_ptr] <= enq_data_i;
        end
    end

    // A full FIFO with no dequeue stays full and keeps its write pointer
    a_full_holds: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (count == CNT_W'(depth)) && !deq_fire |=> (count == CNT_W'(depth)) && $stable(wr_ptr));

    a_count_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        count <= CNT_W'(depth));

endmodule

`default_nettype wire

// ==== hw/vunit_pkg.sv ====
/* Types shared by the unit multiplexer. result_t is only a buffer payload inside the units */
`default_nettype none

`include "vunit_settings.svh"

package vunit_pkg;

    // Execution unit selected by an operation
    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } op_unit_e;

    // ALU opcode, ignored by the multiply unit
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_AND = 2'd2,
        OP_XOR = 2'd3
    } alu_op_e;

    typedef struct packed {
        logic [`VUNIT_ID_W-1:0]   id;
        logic [`VUNIT_VD_W-1:0]   vd;
        logic [`VUNIT_DATA_W-1:0] data;
    } result_t;

endpackage

`default_nettype wire

// ==== include/vunit_settings.svh ====
/* Widths and depths for the unit multiplexer. VUNIT_ORDER_DEPTH bounds the operations in flight.
   VUNIT_MUL_STAGES must be at least 1 */
`ifndef VUNIT_SETTINGS_SVH
`define VUNIT_SETTINGS_SVH

// Operand and result word
`define VUNIT_DATA_W 32
`define VUNIT_ID_W 3
`define VUNIT_VD_W 5

// Queue and buffer depths
`define VUNIT_ORDER_DEPTH 4
`define VUNIT_RES_DEPTH 2

// Multiply pipeline registers ahead of the result buffer
`define VUNIT_MUL_STAGES 2

`endif
